// ==== verilog/eth_types_pkg.sv ====
`default_nettype none

package eth_types_pkg;

	// Stream widths
	typedef logic [31:0] word_t;       // Data word on every stream
	typedef logic [15:0] csum_t;       // One's-complement checksum
	typedef logic [15:0] byte_cnt_t;   // Byte count
	typedef logic [63:0] pkt_num_t;    // Packet number
	typedef logic [1:0]  be_t;         // Valid bytes in eop word, 0 means four

	// One word of the MAC user transmit interface, 36 bits
	typedef struct packed {
		word_t data;   // Big-endian, first byte in [31:24]
		be_t   be;
		logic  eop;
		logic  sop;
	} mac_tx_word_t;

	// Frame builder FSM
	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		PAYLOAD,
		LAST
	} builder_state_t;

endpackage

`default_nettype wire

// ==== verilog/udp_cfg_pkg.sv ====
`default_nettype none

package udp_cfg_pkg;
	import eth_types_pkg::*;

	// Two-pass end-around carry fold of a 32-bit sum
	function automatic csum_t csum_fold(input logic [31:0] sum);
		logic [16:0] part;
		part = {1'b0, sum[31:16]} + {1'b0, sum[15:0]};
		return part[15:0] + {15'd0, part[16]};
	endfunction

	// ----------------------------------------
	// Ethernet
	localparam logic [47:0] MAC_DST_ADDR  = 48'hFF_FF_FF_FF_FF_FF;  // Broadcast
	localparam logic [47:0] MAC_SRC_ADDR  = 48'h04_D4_C4_A5_A8_E1;
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h08_00;

	// IPv4, no options
	localparam logic [3:0]  IP_VERSION     = 4'h4;
	localparam logic [3:0]  IP_HEAD_LEN    = 4'h5;   // In 32-bit words
	localparam logic [7:0]  IP_DSF         = 8'h00;
	localparam logic [15:0] IP_ID          = 16'h64_D7;
	localparam logic [2:0]  IP_FLAGS       = 3'h0;
	localparam logic [12:0] IP_FRAG_OFFSET = 13'h0000;
	localparam logic [7:0]  IP_TTL         = 8'h80;
	localparam logic [7:0]  IP_PROT_UDP    = 8'h11;
	localparam logic [31:0] IP_SRC_ADDR    = 32'hA9_FE_CE_77;  // 169.254.206.119
	localparam logic [31:0] IP_DST_ADDR    = 32'hC1_E8_1A_64;

	// UDP
	localparam logic [15:0] UDP_SRC_PORT = 16'hF718;
	localparam logic [15:0] UDP_DST_PORT = 16'h1EA5;
	localparam byte_cnt_t   PAYLOAD_LEN  = 16'd1447;

	// Lengths derived from the payload
	localparam byte_cnt_t IP_TOTAL_LEN = 16'd20 + 16'd8 + PAYLOAD_LEN;
	localparam byte_cnt_t UDP_LEN      = 16'd8 + PAYLOAD_LEN;
	localparam byte_cnt_t FRAME_LEN    = 16'd42 + PAYLOAD_LEN;
	localparam int        HDR_WORDS    = 10;   // Whole header words before realignment

	// ----------------------------------------
	// Header checksum, all fields constant
	localparam logic [31:0] IP_HEAD_SUM = 32'({IP_VERSION, IP_HEAD_LEN, IP_DSF})
		+ 32'(IP_TOTAL_LEN) + 32'(IP_ID) + 32'({IP_FLAGS, IP_FRAG_OFFSET})
		+ 32'({IP_TTL, IP_PROT_UDP}) + 32'(IP_SRC_ADDR[31:16]) + 32'(IP_SRC_ADDR[15:0])
		+ 32'(IP_DST_ADDR[31:16]) + 32'(IP_DST_ADDR[15:0]);
	localparam csum_t IP_HEAD_CSUM = ~csum_fold(IP_HEAD_SUM);

	// Pseudo-header plus UDP header with checksum field zero
	localparam logic [31:0] UDP_SEED_SUM = 32'(IP_SRC_ADDR[31:16]) + 32'(IP_SRC_ADDR[15:0])
		+ 32'(IP_DST_ADDR[31:16]) + 32'(IP_DST_ADDR[15:0]) + 32'(IP_PROT_UDP)
		+ 32'(UDP_LEN) + 32'(UDP_SRC_PORT) + 32'(UDP_DST_PORT) + 32'(UDP_LEN);
	localparam csum_t UDP_CSUM_SEED = csum_fold(UDP_SEED_SUM);

	// Payload pattern and buffering
	localparam word_t PAYLOAD_FIXED_WORD = 32'h00_01_02_03;
	localparam word_t LAST_WORD_MASK     =
		32'hFFFF_FFFF << (8 * ((4 - int'(PAYLOAD_LEN % 4)) % 4));  // Drops bytes past the end
	localparam int    PAYLOAD_FIFO_DEPTH = 512;
	localparam int    TX_FIFO_DEPTH      = 16;

endpackage

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16   // Power of two, pointers wrap naturally
) (
	input  wire               pll_62_5m_clk,
	input  wire               rst_n,
	input  wire               wr_en_i,
	input  wire [WIDTH-1:0]   wdata_i,
	input  wire               rd_en_i,
	output logic [WIDTH-1:0]  rdata_o,
	output logic              empty_o,
	output logic              full_o
);

	logic [WIDTH-1:0]         mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(DEPTH):0]   count_q;    // Fill level, 0 to DEPTH
	logic                     do_wr;
	logic                     do_rd;

	assign do_wr   = wr_en_i & ~full_o;   // Protect state on a bad push
	assign do_rd   = rd_en_i & ~empty_o;
	assign empty_o = (count_q == '0);
	assign full_o  = (count_q == DEPTH);
	assign rdata_o = mem[rd_ptr_q];       // Head word always visible

	always_ff @(posedge pll_62_5m_clk)
	begin
		if (do_wr)
			mem[wr_ptr_q] <= wdata_i;
	end

	// Pointers and fill count
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_wr & ~do_rd)
				count_q <= count_q + 1'b1;
			else if (do_rd & ~do_wr)
				count_q <= count_q - 1'b1;
		end
	end

	// Producer must honour full, consumer must honour empty
	a_no_write_full: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		wr_en_i |-> !full_o);
	a_no_read_empty: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		rd_en_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== verilog/udp_payload_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_payload_gen
	import eth_types_pkg::*;
	import udp_cfg_pkg::*;
#(
	parameter int SEND_GAP = 250_000_000   // Cycles between frames
) (
	input  wire   pll_62_5m_clk,
	input  wire   rst_n,
	input  wire   frame_done_i,
	output logic  fifo_wr_o,
	output word_t fifo_wdata_o,
	output logic  payload_ready_o,
	output csum_t payload_sum_o
);

	logic [31:0] gap_q;        // Frame gap timer
	logic        busy_q;       // Frame in flight, blocks a second start
	logic        start;
	byte_cnt_t   wr_bytes_q;   // Payload bytes already written
	logic        last_wr;
	pkt_num_t    pkt_num_q;
	word_t       gen_q;        // Word on the FIFO write port
	word_t       sum_word;
	csum_t       sum_q;

	assign start        = (gap_q == '0) & ~busy_q;
	assign last_wr      = fifo_wr_o & ((wr_bytes_q + 16'd4) >= PAYLOAD_LEN);
	assign sum_word     = last_wr ? (gen_q & LAST_WORD_MASK) : gen_q;  // Tail bytes as zero
	assign fifo_wdata_o = gen_q;
	assign payload_sum_o = sum_q;

	// ----------------------------------------
	// Gap timer and frame lock
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			gap_q  <= 32'(SEND_GAP);
			busy_q <= 1'b0;
		end
		else
		begin
			if (frame_done_i)
				gap_q <= 32'(SEND_GAP);   // Reload for the next frame
			else if (gap_q != '0)
				gap_q <= gap_q - 32'd1;
			if (frame_done_i)
				busy_q <= 1'b0;
			else if (start)
				busy_q <= 1'b1;
		end
	end

	// Write burst, one word per cycle
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fifo_wr_o       <= 1'b0;
			wr_bytes_q      <= '0;
			payload_ready_o <= 1'b0;
			pkt_num_q       <= '0;
		end
		else
		begin
			payload_ready_o <= last_wr;   // One cycle after the last write
			if (start)
			begin
				fifo_wr_o  <= 1'b1;
				wr_bytes_q <= '0;
			end
			else if (fifo_wr_o)
			begin
				wr_bytes_q <= wr_bytes_q + 16'd4;
				if (last_wr)
					fifo_wr_o <= 1'b0;
			end
			if (frame_done_i)
				pkt_num_q <= pkt_num_q + 64'd1;
		end
	end

	// ----------------------------------------
	// Payload pattern and running sum
	always_ff @(posedge pll_62_5m_clk)
	begin
		if (start)
		begin
			gen_q <= pkt_num_q[63:32];   // High half first
			sum_q <= '0;
		end
		else if (fifo_wr_o)
		begin
			if (wr_bytes_q == 16'd0)
				gen_q <= pkt_num_q[31:0];
			else if (wr_bytes_q == 16'd4)
				gen_q <= PAYLOAD_FIXED_WORD;
			else
				gen_q <= {gen_q[31:24] + 8'd4, gen_q[23:16] + 8'd4,
					gen_q[15:8] + 8'd4, gen_q[7:0] + 8'd4};   // Each byte plus four
			sum_q <= csum_fold(32'(sum_q) + 32'(sum_word[31:16]) + 32'(sum_word[15:0]));
		end
	end

	// At most one ready per frame handed to the builder
	a_one_ready: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		payload_ready_o |=> (!payload_ready_o until frame_done_i));

endmodule

`default_nettype wire

// ==== verilog/udp_frame_builder.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_frame_builder
	import eth_types_pkg::*;
	import udp_cfg_pkg::*;
(
	input  wire          pll_62_5m_clk,
	input  wire          rst_n,
	input  wire          start_i,
	input  wire csum_t   payload_sum_i,
	output logic         fifo_rd_o,
	input  wire word_t   fifo_rdata_i,
	output logic         out_valid_o,
	output mac_tx_word_t out_word_o,
	input  wire          out_ready_i,
	output logic         frame_done_o
);

	builder_state_t state_q;
	byte_cnt_t      cnt_q;       // Frame bytes already sent
	byte_cnt_t      remain;
	logic [15:0]    carry_q;     // Two bytes held back by the realignment
	logic           xfer;
	logic           last_rd;     // Final word still needs a payload word
	word_t          hdr_word;
	csum_t          udp_sum;
	csum_t          udp_csum;

	assign out_valid_o  = (state_q != IDLE);
	assign xfer         = out_valid_o & out_ready_i;
	assign remain       = FRAME_LEN - cnt_q;
	assign last_rd      = (remain > 16'd2);
	assign fifo_rd_o    = xfer & ((state_q == PAYLOAD) | ((state_q == LAST) & last_rd));
	assign frame_done_o = xfer & (state_q == LAST);

	// Full UDP checksum, zero goes out as all ones
	assign udp_sum  = csum_fold(32'(UDP_CSUM_SEED) + 32'(payload_sum_i));
	assign udp_csum = (udp_sum == 16'hFFFF) ? 16'hFFFF : ~udp_sum;

	// ----------------------------------------
	// Header words, indexed by byte count
	always_comb
	begin
		case (cnt_q[5:2])
			4'd0:    hdr_word = MAC_DST_ADDR[47:16];
			4'd1:    hdr_word = {MAC_DST_ADDR[15:0], MAC_SRC_ADDR[47:32]};
			4'd2:    hdr_word = MAC_SRC_ADDR[31:0];
			4'd3:    hdr_word = {ETH_TYPE_IPV4, IP_VERSION, IP_HEAD_LEN, IP_DSF};
			4'd4:    hdr_word = {IP_TOTAL_LEN, IP_ID};
			4'd5:    hdr_word = {IP_FLAGS, IP_FRAG_OFFSET, IP_TTL, IP_PROT_UDP};
			4'd6:    hdr_word = {IP_HEAD_CSUM, IP_SRC_ADDR[31:16]};
			4'd7:    hdr_word = {IP_SRC_ADDR[15:0], IP_DST_ADDR[31:16]};
			4'd8:    hdr_word = {IP_DST_ADDR[15:0], UDP_SRC_PORT};
			default: hdr_word = {UDP_DST_PORT, UDP_LEN};   // Checksum goes to carry
		endcase
	end

	// Output word from state, carry and FIFO head
	always_comb
	begin
		out_word_o = '0;
		case (state_q)
			HEADER:
			begin
				out_word_o.data = hdr_word;
				out_word_o.sop  = (cnt_q == '0);
			end
			PAYLOAD: out_word_o.data = {carry_q, fifo_rdata_i[31:16]};
			LAST:
			begin
				out_word_o.data = {carry_q, last_rd ? fifo_rdata_i[31:16] : 16'h0000};
				out_word_o.be   = be_t'(remain);   // Count mod four
				out_word_o.eop  = 1'b1;
			end
			default: ;
		endcase
	end

	// ----------------------------------------
	// FSM and byte counter
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= IDLE;
			cnt_q   <= '0;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (start_i)
					begin
						state_q <= HEADER;
						cnt_q   <= '0;
					end
				end
				HEADER, PAYLOAD:
				begin
					if (xfer)
					begin
						cnt_q <= cnt_q + 16'd4;
						if ((cnt_q + 16'd8) >= FRAME_LEN)
							state_q <= LAST;   // Next word closes the frame
						else if (cnt_q == byte_cnt_t'(4 * (HDR_WORDS - 1)))
							state_q <= PAYLOAD;
					end
				end
				LAST:
				begin
					if (xfer)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Realignment carry
	always_ff @(posedge pll_62_5m_clk)
	begin
		if (xfer & (state_q == HEADER))
			carry_q <= udp_csum;   // Only the last header word matters
		else if (xfer & (state_q == PAYLOAD))
			carry_q <= fifo_rdata_i[15:0];
	end

	// Held word under back-pressure
	a_hold_stable: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		(out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_word_o)));

endmodule

`default_nettype wire

// ==== verilog/mac_tx_feeder.sv ====
`timescale 1ns/10ps
`default_nettype none

module mac_tx_feeder
	import eth_types_pkg::*;
	import udp_cfg_pkg::*;
(
	input  wire               pll_62_5m_clk,
	input  wire               rst_n,
	input  wire               in_valid_i,
	input  wire mac_tx_word_t in_word_i,
	output logic              in_ready_o,
	input  wire               tx_wa_i,
	output logic              tx_wr_o,
	output mac_tx_word_t      tx_word_o
);

	logic fifo_empty;
	logic fifo_full;
	logic wr_q;   // Registered write request

	assign in_ready_o = ~fifo_full;
	assign tx_wr_o    = wr_q & ~fifo_empty;   // Never write an empty head

	// Data and control bits in one entry
	sync_fifo #(
		.WIDTH ($bits(mac_tx_word_t)),
		.DEPTH (TX_FIFO_DEPTH)
	) u_tx_fifo (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.wr_en_i       (in_valid_i & in_ready_o),
		.wdata_i       (in_word_i),
		.rd_en_i       (tx_wr_o),        // Pop on every MAC write
		.rdata_o       (tx_word_o),
		.empty_o       (fifo_empty),
		.full_o        (fifo_full)
	);

	// Follows write-allowed one cycle late
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
			wr_q <= 1'b0;
		else
			wr_q <= tx_wa_i & ~fifo_empty;
	end

	// MAC sees a write only after granting it
	a_wr_after_wa: assert property (@(posedge pll_62_5m_clk) disable iff (!rst_n)
		tx_wr_o |-> $past(tx_wa_i));

endmodule

`default_nettype wire

// ==== verilog/udp_test_source.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_test_source
	import eth_types_pkg::*;
	import udp_cfg_pkg::*;
#(
	parameter int SEND_GAP = 250_000_000
) (
	input  wire          pll_62_5m_clk,
	input  wire          rst_n,
	input  wire          tx_wa_i,
	output logic         tx_wr_o,
	output mac_tx_word_t tx_word_o
);

	logic         gen_wr;          // Generator to payload FIFO
	word_t        gen_wdata;
	logic         payload_ready;   // Generator to builder
	csum_t        payload_sum;
	logic         frame_done;
	logic         pay_rd;          // Builder reads payload FIFO
	word_t        pay_rdata;
	logic         bld_valid;       // Builder to feeder
	mac_tx_word_t bld_word;
	logic         bld_ready;

	udp_payload_gen #(
		.SEND_GAP (SEND_GAP)
	) u_payload_gen (
		.pll_62_5m_clk   (pll_62_5m_clk),
		.rst_n           (rst_n),
		.frame_done_i    (frame_done),
		.fifo_wr_o       (gen_wr),
		.fifo_wdata_o    (gen_wdata),
		.payload_ready_o (payload_ready),
		.payload_sum_o   (payload_sum)
	);

	// Holds one whole payload
	sync_fifo #(
		.WIDTH ($bits(word_t)),
		.DEPTH (PAYLOAD_FIFO_DEPTH)
	) u_payload_fifo (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.wr_en_i       (gen_wr),
		.wdata_i       (gen_wdata),
		.rd_en_i       (pay_rd),
		.rdata_o       (pay_rdata),
		.empty_o       (),
		.full_o        ()
	);

	udp_frame_builder u_frame_builder (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.start_i       (payload_ready),
		.payload_sum_i (payload_sum),
		.fifo_rd_o     (pay_rd),
		.fifo_rdata_i  (pay_rdata),
		.out_valid_o   (bld_valid),
		.out_word_o    (bld_word),
		.out_ready_i   (bld_ready),
		.frame_done_o  (frame_done)
	);

	mac_tx_feeder u_mac_tx_feeder (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.in_valid_i    (bld_valid),
		.in_word_i     (bld_word),
		.in_ready_o    (bld_ready),
		.tx_wa_i       (tx_wa_i),
		.tx_wr_o       (tx_wr_o),
		.tx_word_o     (tx_word_o)
	);

endmodule

`default_nettype wire

// ==== sim/tb_udp_test_source.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_udp_test_source
	import eth_types_pkg::*;
	import udp_cfg_pkg::*;
();

	localparam int        SEND_GAP    = 200;
	localparam int        CLK_PERIOD  = 200;
	localparam int        DRIVE_DELAY = 1;      // After the rising edge
	localparam int        WAIT_LIMIT  = 4000;   // Cycles per wait loop
	localparam int        MAX_TESTS   = 5;
	localparam byte_cnt_t EXP_IP_LEN    = 16'd28 + PAYLOAD_LEN;   // IP header + UDP header
	localparam byte_cnt_t EXP_UDP_LEN   = 16'd8 + PAYLOAD_LEN;
	localparam byte_cnt_t EXP_FRAME_LEN = 16'd42 + PAYLOAD_LEN;
	localparam int        FRAME_WORDS   = (int'(EXP_FRAME_LEN) + 3) / 4;
	localparam int        PAYLOAD_WORDS = (int'(PAYLOAD_LEN) + 3) / 4;   // Generator burst length

	logic         pll_62_5m_clk = 1'b0;
	logic         rst_n = 1'b0;
	logic         tx_wa_i = 1'b0;
	logic         tx_wr_o;
	mac_tx_word_t tx_word_o;

	logic [15:0] tests [3 * MAX_TESTS];   // Frames, stall percent, quiet flag
	logic [7:0]  frame_bytes [2048];      // Expected frame with zeros past the end
	csum_t       exp_ip_csum;
	csum_t       exp_udp_csum;
	integer      seed = 58;
	integer      rnd;
	int          stall_pct = 0;
	int          error_count = 0;
	int          t;
	logic        wa_prev = 1'b0;          // tx_wa_i one cycle back

	always #(CLK_PERIOD / 2) pll_62_5m_clk = ~pll_62_5m_clk;

	udp_test_source #(
		.SEND_GAP (SEND_GAP)
	) u_dut (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.tx_wa_i       (tx_wa_i),
		.tx_wr_o       (tx_wr_o),
		.tx_word_o     (tx_word_o)
	);

	// ----------------------------------------
	// Error reporting and compare tasks
	task automatic stop_run();
		error_count++;
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_plain(input string what);
		$display("%0t: %s", $time, what);
		stop_run();
	endtask

	// Field view of one MAC word
	function automatic string word_text(input mac_tx_word_t w);
		return $sformatf("data=%h be=%0d eop=%b sop=%b", w.data, w.be, w.eop, w.sop);
	endfunction

	task automatic check_word(input string name, input mac_tx_word_t got,
		input mac_tx_word_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %s, expected %s", $time, name,
				word_text(got), word_text(exp));
			stop_run();
		end
	endtask

	task automatic check_csum(input string name, input csum_t got, input csum_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input byte_cnt_t got, input byte_cnt_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	// End-around carry add of one 16-bit word
	function automatic csum_t ones_add(input csum_t a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]};
	endfunction

	// ----------------------------------------
	// Reference frame for one packet number
	task automatic build_frame(input pkt_num_t num);
		logic [42*8-1:0] hdr;
		csum_t           sum;
		hdr = {MAC_DST_ADDR, MAC_SRC_ADDR, ETH_TYPE_IPV4, IP_VERSION, IP_HEAD_LEN, IP_DSF,
			EXP_IP_LEN, IP_ID, IP_FLAGS, IP_FRAG_OFFSET, IP_TTL, IP_PROT_UDP, 16'h0000,
			IP_SRC_ADDR, IP_DST_ADDR, UDP_SRC_PORT, UDP_DST_PORT, EXP_UDP_LEN, 16'h0000};
		for (int i = 0; i < 2048; i++)
			frame_bytes[i] = 8'h00;
		for (int i = 0; i < 42; i++)
			frame_bytes[i] = hdr[8*(41-i) +: 8];
		// Packet number big-endian then a byte ramp from the fixed word on
		for (int k = 0; k < int'(PAYLOAD_LEN); k++)
			frame_bytes[42+k] = (k < 8) ? num[8*(7-k) +: 8] : 8'(k - 8);
		sum = '0;
		for (int i = 14; i < 34; i += 2)   // IP header only
			sum = ones_add(sum, {frame_bytes[i], frame_bytes[i+1]});
		exp_ip_csum = ~sum;
		frame_bytes[24] = exp_ip_csum[15:8];
		frame_bytes[25] = exp_ip_csum[7:0];
		// Pseudo-header
		sum = ones_add('0, IP_SRC_ADDR[31:16]);
		sum = ones_add(sum, IP_SRC_ADDR[15:0]);
		sum = ones_add(sum, IP_DST_ADDR[31:16]);
		sum = ones_add(sum, IP_DST_ADDR[15:0]);
		sum = ones_add(sum, {8'h00, IP_PROT_UDP});
		sum = ones_add(sum, EXP_UDP_LEN);
		for (int i = 34; i < int'(EXP_FRAME_LEN); i += 2)   // Odd tail padded by zero
			sum = ones_add(sum, {frame_bytes[i], frame_bytes[i+1]});
		exp_udp_csum = (~sum == 16'h0000) ? 16'hFFFF : ~sum;
		frame_bytes[40] = exp_udp_csum[15:8];
		frame_bytes[41] = exp_udp_csum[7:0];
	endtask

	// ----------------------------------------
	// MAC side
	always @(posedge pll_62_5m_clk)
	begin
		#DRIVE_DELAY;
		rnd = $random(seed);
		tx_wa_i = ((rnd & 32'h7FFF_FFFF) % 100) >= stall_pct;   // Low with stall odds
	end

	// Write only after a grant
	always @(negedge pll_62_5m_clk)
	begin
		if (rst_n && (tx_wr_o === 1'b1) && !wa_prev)
			fail_plain("tx_wr_o high without tx_wa_i in the previous cycle");
		wa_prev = tx_wa_i;
	end

	task automatic next_write(output mac_tx_word_t w);
		int n;
		n = 0;
		@(negedge pll_62_5m_clk);
		while (tx_wr_o !== 1'b1)
		begin
			n++;
			if (n > WAIT_LIMIT)
				fail_plain("timeout waiting for a word on tx_wr_o");
			@(negedge pll_62_5m_clk);
		end
		w = tx_word_o;
	endtask

	task automatic receive_frame(input pkt_num_t num);
		mac_tx_word_t got;
		mac_tx_word_t exp;
		int           nvalid;
		byte_cnt_t    rx_bytes;
		build_frame(num);
		rx_bytes = '0;
		for (int i = 0; i < FRAME_WORDS; i++)
		begin
			next_write(got);
			exp      = '0;
			exp.data = {frame_bytes[4*i], frame_bytes[4*i+1],
				frame_bytes[4*i+2], frame_bytes[4*i+3]};
			exp.sop  = (i == 0);
			if (i == FRAME_WORDS - 1)
			begin
				exp.eop = 1'b1;
				exp.be  = be_t'(EXP_FRAME_LEN % 4);
			end
			nvalid   = (exp.eop && exp.be != 0) ? int'(exp.be) : 4;
			got.data = got.data & (32'hFFFF_FFFF << (8 * (4 - nvalid)));   // Tail is don't care
			rx_bytes += (got.eop && got.be != 0) ? byte_cnt_t'(got.be) : 16'd4;
			if (i == 6)
				check_csum("ip header checksum", got.data[31:16], exp_ip_csum);
			if (i == 10)
				check_csum("udp checksum", got.data[31:16], exp_udp_csum);
			check_word($sformatf("tx_word_o[%0d] of packet %0d", i, num), got, exp);
		end
		check_count("frame bytes", rx_bytes, EXP_FRAME_LEN);
	endtask

	task automatic apply_reset();
		@(posedge pll_62_5m_clk);
		#DRIVE_DELAY rst_n = 1'b0;
		repeat (10) @(posedge pll_62_5m_clk);
		#DRIVE_DELAY rst_n = 1'b1;
	endtask

	// No write during the first frame gap and the payload burst after it
	task automatic check_reset_quiet();
		for (int c = 0; c < SEND_GAP + PAYLOAD_WORDS; c++)
		begin
			@(negedge pll_62_5m_clk);
			if (tx_wr_o !== 1'b0)
				fail_plain($sformatf("tx_wr_o high %0d cycles after reset", c));
		end
	endtask

	task automatic run_test(input int frames, input int pct, input logic quiet);
		stall_pct = pct;
		apply_reset();
		if (quiet)
			check_reset_quiet();
		for (int f = 0; f < frames; f++)
			receive_frame(pkt_num_t'(f));   // Numbers restart at reset
		$display("%0t: %0d frames done at %0d%% stall", $time, frames, pct);
	endtask

	// ----------------------------------------
	initial
	begin
		for (int i = 0; i < 3 * MAX_TESTS; i++)
			tests[i] = '0;
		$readmemh("sim/udp_source_tests.txt", tests);
		t = 0;
		while ((t < MAX_TESTS) && (tests[3*t] != '0))
		begin
			run_test(int'(tests[3*t]), int'(tests[3*t+1]), tests[3*t+2][0]);
			t++;
		end
		if (t == 0)
			fail_plain("no test lines read from the data file");
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/udp_source_tests.txt ====
// Columns in hex: frame count, tx_wa_i stall percent, reset-quiet check flag
// A zero frame count ends the list
2 00 1
3 19 0
2 32 1
1 5a 0
0 00 0

// ==== udp_test_source.f ====
verilog/eth_types_pkg.sv
verilog/udp_cfg_pkg.sv
verilog/sync_fifo.sv
verilog/udp_payload_gen.sv
verilog/udp_frame_builder.sv
verilog/mac_tx_feeder.sv
verilog/udp_test_source.sv
sim/tb_udp_test_source.sv

// ==== Bender.yml ====
package:
  name: udp_test_source

sources:
  - files:
      - verilog/eth_types_pkg.sv
      - verilog/udp_cfg_pkg.sv
      - verilog/sync_fifo.sv
      - verilog/udp_payload_gen.sv
      - verilog/udp_frame_builder.sv
      - verilog/mac_tx_feeder.sv
      - verilog/udp_test_source.sv
  - target: test
    files:
      - sim/tb_udp_test_source.sv
